//--- hdl/screen_layout_pkg.sv
package screen_layout_pkg;

    //////////////////////////////////////////////////
    // cell grid, 16x32 pixel cells on 640x480
    //////////////////////////////////////////////////

    localparam int CELL_COL_W = 6;                  // pix_x[9:4]
    localparam int CELL_ROW_W = 5;                  // pix_y[9:5]

    localparam logic [CELL_COL_W-1:0] LAST_COL = 6'd39;    // right border column

    // vertical border limits in pixels
    localparam logic [9:0] TOP_EDGE_Y    = 10'd32;
    localparam logic [9:0] BOTTOM_EDGE_Y = 10'd448;

    //////////////////////////////////////////////////
    // text rows and column ranges
    //////////////////////////////////////////////////

    localparam logic [CELL_ROW_W-1:0] DATE_ROW    = 5'd1;
    localparam logic [CELL_ROW_W-1:0] HOUR_ROW    = 5'd3;
    localparam logic [CELL_ROW_W-1:0] DIVIDER_ROW = 5'd8;

    localparam logic [CELL_COL_W-1:0] LABEL_FIRST_COL = 6'd5;    // "Fecha" / "Hora"
    localparam logic [CELL_COL_W-1:0] DATE_LABEL_LAST = 6'd9;
    localparam logic [CELL_COL_W-1:0] HOUR_LABEL_LAST = 6'd8;

    localparam logic [CELL_COL_W-1:0] FIELD_FIRST_COL = 6'd15;   // first digit cell
    localparam logic [CELL_COL_W-1:0] FIELD_LAST_COL  = 6'd22;   // last digit cell
    localparam logic [CELL_COL_W-1:0] AMPM_COL        = 6'd24;   // 'm' sits one cell right

    // cursor position 0..5 to the digit cell it edits, separators skipped
    localparam logic [CELL_COL_W-1:0] CURSOR_COL [6] = '{
        6'd15,
        6'd16,
        6'd18,
        6'd19,
        6'd21,
        6'd22
    };

    //////////////////////////////////////////////////
    // edit mode, dir_prog encoding
    //////////////////////////////////////////////////

    localparam logic [1:0] EDIT_NONE = 2'd0;
    localparam logic [1:0] EDIT_HOUR = 2'd1;
    localparam logic [1:0] EDIT_DATE = 2'd2;

endpackage

//--- hdl/glyph_pkg.sv
package glyph_pkg;

    typedef logic [6:0] char_code_t;
    typedef logic [11:0] color_t;

    //////////////////////////////////////////////////
    // character codes in the font memory
    //////////////////////////////////////////////////

    localparam char_code_t CH_BLANK   = 7'h00;
    localparam char_code_t DIGIT_BASE = 7'h30;   // '0', plus the bcd nibble
    localparam char_code_t CH_COLON   = 7'h3a;
    localparam char_code_t CH_SLASH   = 7'h2f;
    localparam char_code_t CH_SUFFIX_A = 7'h61;  // a
    localparam char_code_t CH_SUFFIX_P = 7'h70;  // p
    localparam char_code_t CH_SUFFIX_M = 7'h6d;  // m

    // frame pieces
    localparam char_code_t BORDER_TOP    = 7'h14;
    localparam char_code_t BORDER_BOTTOM = 7'h17;
    localparam char_code_t BORDER_LEFT   = 7'h13;
    localparam char_code_t BORDER_RIGHT  = 7'h15;
    localparam char_code_t DIVIDER       = 7'h16;
    localparam char_code_t CORNER_UL     = 7'h0f;
    localparam char_code_t CORNER_UR     = 7'h10;
    localparam char_code_t CORNER_DR     = 7'h11;
    localparam char_code_t CORNER_DL     = 7'h12;

    //////////////////////////////////////////////////
    // colours and colour class
    //////////////////////////////////////////////////

    localparam color_t COLOR_BG    = 12'hccc;   // light grey
    localparam color_t COLOR_TEXT  = 12'h00b;   // navy
    localparam color_t COLOR_FRAME = 12'h444;   // dark grey

    localparam logic [1:0] CLASS_NONE  = 2'd0;
    localparam logic [1:0] CLASS_TEXT  = 2'd1;
    localparam logic [1:0] CLASS_FRAME = 2'd2;

    // 11-bit font address, raw word or char code above glyph row
    typedef union packed {
        logic [10:0] raw;
        struct packed {
            char_code_t code;
            logic [3:0] row;
        } f;
    } font_addr_u;

endpackage

//--- hdl/clock_field_decoder.sv
`timescale 1ns/1ps

module clock_field_decoder (
    input  logic                  nexys_clock,
    input  logic                  rst_n,
    input  logic [9:0]            pix_x,
    input  logic [9:0]            pix_y,
    input  logic [7:0]            hora,
    input  logic [7:0]            min,
    input  logic [7:0]            seg,
    input  logic [7:0]            dia,
    input  logic [7:0]            mes,
    input  logic [7:0]            year,
    input  logic                  am_pm,
    input  logic                  formato,
    input  logic                  clk_parp,
    input  logic [1:0]            dir_prog,
    input  logic [2:0]            p_hora,
    input  logic [2:0]            p_fecha,
    output logic                  field_hit,
    output glyph_pkg::char_code_t field_char,
    output logic                  field_blank
);

    logic [screen_layout_pkg::CELL_COL_W-1:0] cell_col;
    logic [screen_layout_pkg::CELL_ROW_W-1:0] cell_row;
    logic [screen_layout_pkg::CELL_COL_W-1:0] lbl_off;
    logic [screen_layout_pkg::CELL_COL_W-1:0] fld_off;
    logic [screen_layout_pkg::CELL_COL_W-1:0] cur_col;
    logic                  on_date;
    logic                  on_hour;
    logic [7:0]            val_a;
    logic [7:0]            val_b;
    logic [7:0]            val_c;
    glyph_pkg::char_code_t sep_char;
    glyph_pkg::char_code_t char_next;
    logic                  hit_next;
    logic                  blank_next;
    logic                  edit_row;
    logic [2:0]            cur_pos;

    function automatic glyph_pkg::char_code_t bcd_char(input logic [3:0] nib);
        return glyph_pkg::DIGIT_BASE + {3'b000, nib};
    endfunction

    assign cell_col = pix_x[9:4];
    assign cell_row = pix_y[9:5];
    assign on_date  = (cell_row == screen_layout_pkg::DATE_ROW);
    assign on_hour  = (cell_row == screen_layout_pkg::HOUR_ROW);
    assign lbl_off  = cell_col - screen_layout_pkg::LABEL_FIRST_COL;
    assign fld_off  = cell_col - screen_layout_pkg::FIELD_FIRST_COL;

    // both rows share one digit layout, only the sources differ
    assign val_a    = on_date ? dia  : hora;
    assign val_b    = on_date ? mes  : min;
    assign val_c    = on_date ? year : seg;
    assign sep_char = on_date ? glyph_pkg::CH_SLASH : glyph_pkg::CH_COLON;

    always_comb
    begin
        hit_next  = 1'b0;
        char_next = glyph_pkg::CH_BLANK;
        if (on_date && cell_col >= screen_layout_pkg::LABEL_FIRST_COL
                && cell_col <= screen_layout_pkg::DATE_LABEL_LAST)
        begin
            hit_next = 1'b1;
            case (lbl_off[2:0])
                3'd0:    char_next = 7'h46;     // F
                3'd1:    char_next = 7'h65;     // e
                3'd2:    char_next = 7'h63;     // c
                3'd3:    char_next = 7'h68;     // h
                default: char_next = 7'h61;     // a
            endcase
        end
        else if (on_hour && cell_col >= screen_layout_pkg::LABEL_FIRST_COL
                && cell_col <= screen_layout_pkg::HOUR_LABEL_LAST)
        begin
            hit_next = 1'b1;
            case (lbl_off[1:0])
                2'd0:    char_next = 7'h48;     // H
                2'd1:    char_next = 7'h6f;     // o
                2'd2:    char_next = 7'h72;     // r
                default: char_next = 7'h61;     // a
            endcase
        end
        else if ((on_date || on_hour) && cell_col >= screen_layout_pkg::FIELD_FIRST_COL
                && cell_col <= screen_layout_pkg::FIELD_LAST_COL)
        begin
            hit_next = 1'b1;
            case (fld_off[2:0])
                3'd0:    char_next = bcd_char(val_a[7:4]);   // tens
                3'd1:    char_next = bcd_char(val_a[3:0]);
                3'd3:    char_next = bcd_char(val_b[7:4]);
                3'd4:    char_next = bcd_char(val_b[3:0]);
                3'd6:    char_next = bcd_char(val_c[7:4]);
                3'd7:    char_next = bcd_char(val_c[3:0]);
                default: char_next = sep_char;              // cells 2 and 5
            endcase
        end
        else if (on_hour && cell_col > screen_layout_pkg::FIELD_LAST_COL
                && cell_col <= screen_layout_pkg::AMPM_COL + 6'd1)
        begin
            hit_next = 1'b1;                    // gap cell and suffix, blank in 24h
            if (formato && cell_col == screen_layout_pkg::AMPM_COL)
                char_next = am_pm ? glyph_pkg::CH_SUFFIX_P : glyph_pkg::CH_SUFFIX_A;
            else if (formato && cell_col != screen_layout_pkg::FIELD_LAST_COL + 6'd1)
                char_next = glyph_pkg::CH_SUFFIX_M;
        end
    end

    //////////////////////////////////////////////////
    // edit cursor blink
    //////////////////////////////////////////////////

    always_comb
    begin
        cur_pos = on_hour ? p_hora : p_fecha;
        cur_col = '1;                           // no cell matches
        if (cur_pos <= 3'd5)
            cur_col = screen_layout_pkg::CURSOR_COL[cur_pos];
        case (dir_prog)
            screen_layout_pkg::EDIT_HOUR: edit_row = on_hour;
            screen_layout_pkg::EDIT_DATE: edit_row = on_date;
            screen_layout_pkg::EDIT_NONE: edit_row = 1'b0;
            default:                      edit_row = 1'b0;
        endcase
        blank_next = edit_row && (cell_col == cur_col) && !clk_parp;
    end

    always_ff @(posedge nexys_clock)
    begin
        if (!rst_n)
        begin
            field_hit   <= 1'b0;
            field_blank <= 1'b0;
        end
        else
        begin
            field_hit   <= hit_next;
            field_blank <= blank_next;
        end
        field_char <= char_next;
    end

endmodule

//--- hdl/frame_decoder.sv
`timescale 1ns/1ps

module frame_decoder (
    input  logic                  nexys_clock,
    input  logic                  rst_n,
    input  logic [9:0]            pix_x,
    input  logic [9:0]            pix_y,
    output logic                  frame_hit,
    output glyph_pkg::char_code_t frame_char
);

    logic [screen_layout_pkg::CELL_COL_W-1:0] cell_col;
    logic [screen_layout_pkg::CELL_ROW_W-1:0] cell_row;
    logic                  in_top;
    logic                  in_bottom;
    logic                  in_left;
    logic                  in_right;
    logic                  inner_col;
    logic                  hit_next;
    glyph_pkg::char_code_t char_next;

    assign cell_col  = pix_x[9:4];
    assign cell_row  = pix_y[9:5];
    assign in_top    = (pix_y < screen_layout_pkg::TOP_EDGE_Y);
    assign in_bottom = (pix_y >= screen_layout_pkg::BOTTOM_EDGE_Y);
    assign in_left   = (cell_col == '0);
    assign in_right  = (cell_col == screen_layout_pkg::LAST_COL);
    assign inner_col = !in_left && (cell_col < screen_layout_pkg::LAST_COL);   // cols 1..38

    always_comb
    begin
        hit_next  = 1'b1;
        char_next = glyph_pkg::CH_BLANK;
        if (in_top && in_left)
            char_next = glyph_pkg::CORNER_UL;
        else if (in_top && in_right)
            char_next = glyph_pkg::CORNER_UR;
        else if (in_bottom && in_left)
            char_next = glyph_pkg::CORNER_DL;
        else if (in_bottom && in_right)
            char_next = glyph_pkg::CORNER_DR;
        else if (in_top && inner_col)
            char_next = glyph_pkg::BORDER_TOP;
        else if (in_bottom && inner_col)
            char_next = glyph_pkg::BORDER_BOTTOM;
        else if (!in_top && !in_bottom && in_left)
            char_next = glyph_pkg::BORDER_LEFT;
        else if (!in_top && !in_bottom && in_right)
            char_next = glyph_pkg::BORDER_RIGHT;
        else if (cell_row == screen_layout_pkg::DIVIDER_ROW && inner_col)
            char_next = glyph_pkg::DIVIDER;     // line under the clock rows
        else
            hit_next = 1'b0;
    end

    always_ff @(posedge nexys_clock)
    begin
        if (!rst_n)
            frame_hit <= 1'b0;
        else
            frame_hit <= hit_next;
        frame_char <= char_next;
    end

endmodule

//--- hdl/pixel_shader.sv
`timescale 1ns/1ps

module pixel_shader (
    input  logic                  nexys_clock,
    input  logic                  rst_n,
    input  logic [9:0]            pix_x,
    input  logic [9:0]            pix_y,
    input  logic                  field_hit,
    input  logic                  field_blank,
    input  logic                  frame_hit,
    input  glyph_pkg::char_code_t field_char,
    input  glyph_pkg::char_code_t frame_char,
    input  logic [7:0]            font_row,
    output logic [10:0]           font_addr,
    output glyph_pkg::color_t     color
);

    glyph_pkg::font_addr_u addr_next;
    glyph_pkg::font_addr_u addr_q;
    logic [3:0] glyph_row_d;
    logic [2:0] bit_col_d;
    logic [2:0] bit_col_q2;
    logic [2:0] bit_col_q3;
    logic [1:0] class_next;
    logic [1:0] class_q2;
    logic [1:0] class_q3;
    logic       blank_q2;
    logic       blank_q3;
    logic       font_bit;

    // glyph drawn at double size, so pixel bit 0 is dropped
    always_ff @(posedge nexys_clock)
    begin
        glyph_row_d <= pix_y[4:1];
        bit_col_d   <= pix_x[3:1];
    end

    //////////////////////////////////////////////////
    // character select and font address
    //////////////////////////////////////////////////

    always_comb
    begin
        addr_next.f.code = glyph_pkg::CH_BLANK;
        addr_next.f.row  = glyph_row_d;
        class_next       = glyph_pkg::CLASS_NONE;
        if (field_hit)
        begin
            addr_next.f.code = field_char;      // clock text wins
            class_next       = glyph_pkg::CLASS_TEXT;
        end
        else if (frame_hit)
        begin
            addr_next.f.code = frame_char;
            class_next       = glyph_pkg::CLASS_FRAME;
        end
    end

    always_ff @(posedge nexys_clock)
    begin
        if (!rst_n)
        begin
            addr_q.raw <= '0;
            class_q2   <= glyph_pkg::CLASS_NONE;
            blank_q2   <= 1'b0;
        end
        else
        begin
            addr_q   <= addr_next;
            class_q2 <= class_next;
            blank_q2 <= field_hit && field_blank;
        end
        bit_col_q2 <= bit_col_d;
    end

    assign font_addr = addr_q.raw;

    //////////////////////////////////////////////////
    // wait for font_row, then colour
    //////////////////////////////////////////////////

    always_ff @(posedge nexys_clock)
    begin
        if (!rst_n)
        begin
            class_q3 <= glyph_pkg::CLASS_NONE;
            blank_q3 <= 1'b0;
        end
        else
        begin
            class_q3 <= class_q2;               // memory read in flight
            blank_q3 <= blank_q2;
        end
        bit_col_q3 <= bit_col_q2;
    end

    assign font_bit = font_row[3'd7 - bit_col_q3];    // msb is leftmost

    always_ff @(posedge nexys_clock)
    begin
        if (!rst_n)
            color <= glyph_pkg::COLOR_BG;
        else if (blank_q3)
            color <= glyph_pkg::COLOR_BG;       // cursor digit off phase
        else if (font_bit && class_q3 == glyph_pkg::CLASS_TEXT)
            color <= glyph_pkg::COLOR_TEXT;
        else if (font_bit && class_q3 == glyph_pkg::CLASS_FRAME)
            color <= glyph_pkg::COLOR_FRAME;
        else
            color <= glyph_pkg::COLOR_BG;
    end

endmodule

//--- hdl/char_overlay.sv
`timescale 1ns/1ps

module char_overlay (
    input  logic              nexys_clock,
    input  logic              rst_n,
    input  logic [9:0]        pix_x,
    input  logic [9:0]        pix_y,
    input  logic [7:0]        hora,
    input  logic [7:0]        min,
    input  logic [7:0]        seg,
    input  logic [7:0]        dia,
    input  logic [7:0]        mes,
    input  logic [7:0]        year,
    input  logic              am_pm,
    input  logic              formato,
    input  logic              clk_parp,         // blink level
    input  logic [1:0]        dir_prog,
    input  logic [2:0]        p_hora,
    input  logic [2:0]        p_fecha,
    input  logic [7:0]        font_row,         // external font, one clock after font_addr
    output logic [10:0]       font_addr,
    output glyph_pkg::color_t color
);

    logic                  field_hit;
    logic                  field_blank;
    logic                  frame_hit;
    glyph_pkg::char_code_t field_char;
    glyph_pkg::char_code_t frame_char;

    clock_field_decoder i_clock_field_decoder (
        .nexys_clock (nexys_clock),
        .rst_n       (rst_n),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .hora        (hora),
        .min         (min),
        .seg         (seg),
        .dia         (dia),
        .mes         (mes),
        .year        (year),
        .am_pm       (am_pm),
        .formato     (formato),
        .clk_parp    (clk_parp),
        .dir_prog    (dir_prog),
        .p_hora      (p_hora),
        .p_fecha     (p_fecha),
        .field_hit   (field_hit),
        .field_char  (field_char),
        .field_blank (field_blank)
    );

    frame_decoder i_frame_decoder (
        .nexys_clock (nexys_clock),
        .rst_n       (rst_n),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .frame_hit   (frame_hit),
        .frame_char  (frame_char)
    );

    pixel_shader i_pixel_shader (
        .nexys_clock (nexys_clock),
        .rst_n       (rst_n),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .field_hit   (field_hit),
        .field_blank (field_blank),
        .frame_hit   (frame_hit),
        .field_char  (field_char),
        .frame_char  (frame_char),
        .font_row    (font_row),
        .font_addr   (font_addr),
        .color       (color)
    );

endmodule

//--- dv/char_overlay_props.sv
`timescale 1ns/1ps

module char_overlay_props (
    input logic              nexys_clock,
    input logic              rst_n,
    input logic              field_hit,
    input logic              field_blank,
    input glyph_pkg::color_t color
);

    int unsigned fail_count = 0;

    color_in_palette: assert property (@(posedge nexys_clock) disable iff (!rst_n)
        color == glyph_pkg::COLOR_BG || color == glyph_pkg::COLOR_TEXT
            || color == glyph_pkg::COLOR_FRAME)
    else
    begin
        $error("color is not one of the three palette entries");
        fail_count++;
    end

    bg_after_reset: assert property (@(posedge nexys_clock)
        !rst_n |=> color == glyph_pkg::COLOR_BG)
    else
    begin
        $error("color is not background after a reset cycle");
        fail_count++;
    end

    // blank flag reaches color through blank_q2, blank_q3
    blank_gives_bg: assert property (@(posedge nexys_clock) disable iff (!rst_n)
        field_hit && field_blank |-> ##3 color == glyph_pkg::COLOR_BG)
    else
    begin
        $error("blanked cursor digit was not drawn as background");
        fail_count++;
    end

endmodule

bind pixel_shader char_overlay_props i_props (
    .nexys_clock (nexys_clock),
    .rst_n       (rst_n),
    .field_hit   (field_hit),
    .field_blank (field_blank),
    .color       (color)
);

//--- dv/char_overlay_tb.sv
`timescale 1ns/1ps

module char_overlay_tb;

    localparam int RESET_TIMEOUT = 20;

    typedef struct {
        logic [9:0]  x;
        logic [9:0]  y;
        logic [47:0] clk_vals;      // hora min seg dia mes year
        logic [1:0]  dir_prog;
        logic [2:0]  p_hora;
        logic [2:0]  p_fecha;
        logic        formato;
        logic        am_pm;
        logic        clk_parp;
        logic [6:0]  code;          // expected char code
        logic [1:0]  cls;           // expected colour class
        logic        blank;         // expected cursor blank
    } entry_t;

    logic              nexys_clock = 1'b0;
    logic              rst_n;
    logic [9:0]        pix_x;
    logic [9:0]        pix_y;
    logic [7:0]        hora;
    logic [7:0]        min;
    logic [7:0]        seg;
    logic [7:0]        dia;
    logic [7:0]        mes;
    logic [7:0]        year;
    logic              am_pm;
    logic              formato;
    logic              clk_parp;
    logic [1:0]        dir_prog;
    logic [2:0]        p_hora;
    logic [2:0]        p_fecha;
    logic [7:0]        font_row = 8'h00;
    logic [10:0]       font_addr;
    glyph_pkg::color_t color;

    entry_t      stim[$];
    entry_t      cur;
    logic [31:0] rng;
    int          waited;
    string       date_label = "Fecha";
    string       hour_label = "Hora";

    char_overlay i_dut (.*);

    always #5 nexys_clock = ~nexys_clock;

    //////////////////////////////////////////////////
    // font memory model with one clock of read latency
    //////////////////////////////////////////////////

    function automatic logic [7:0] font_memory_row(input logic [10:0] addr);
        return addr[7:0] ^ {addr[10:4], 1'b0};  // low byte xor code << 1
    endfunction

    always @(posedge nexys_clock)
        font_row <= font_memory_row(font_addr);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    // off counts cells from the first digit cell and vals holds three bcd bytes
    function automatic logic [6:0] field_code(input int off, input logic [23:0] vals,
                                              input logic [6:0] sep);
        int n;
        n = off - off / 3;
        if (off % 3 == 2)
            return sep;
        return glyph_pkg::DIGIT_BASE + {3'b000, vals[23 - 4 * n -: 4]};
    endfunction

    function automatic glyph_pkg::color_t expected_color(input entry_t e);
        logic [7:0] bits;
        logic       fbit;
        bits = font_memory_row({e.code, e.y[4:1]});
        fbit = bits[3'd7 - e.x[3:1]];
        if (e.blank)
            return glyph_pkg::COLOR_BG;
        else if (fbit && e.cls == glyph_pkg::CLASS_TEXT)
            return glyph_pkg::COLOR_TEXT;
        else if (fbit && e.cls == glyph_pkg::CLASS_FRAME)
            return glyph_pkg::COLOR_FRAME;
        return glyph_pkg::COLOR_BG;
    endfunction

    task automatic draw_clock_values();
        for (int k = 0; k < 12; k++)
        begin
            rng = xorshift(rng);
            cur.clk_vals[4 * k +: 4] = 4'(rng % 10);   // one bcd digit
        end
    endtask

    // random pixel inside the given cell with the modes from cur
    task automatic add_cell(input int col, input int row, input logic [6:0] code,
                            input logic [1:0] cls, input logic blank);
        entry_t e;
        rng     = xorshift(rng);
        e       = cur;
        e.x     = 10'(col * 16) + {6'd0, rng[3:0]};
        e.y     = 10'(row * 32) + {5'd0, rng[8:4]};
        e.code  = code;
        e.cls   = cls;
        e.blank = blank;
        stim.push_back(e);
    endtask

    // text pixel with a set font bit so that blanking changes the colour
    task automatic add_lit_cell(input int col, input int row, input logic [6:0] code,
                                input logic blank);
        entry_t e;
        int     tries;
        tries = 0;
        do
        begin
            if (tries > 0)
                void'(stim.pop_back());
            add_cell(col, row, code, glyph_pkg::CLASS_TEXT, 1'b0);
            tries++;
        end
        while (expected_color(stim[$]) != glyph_pkg::COLOR_TEXT && tries < 64);
        e       = stim.pop_back();
        e.blank = blank;
        stim.push_back(e);
    endtask

    task automatic apply_entry(input entry_t e);
        pix_x    = e.x;
        pix_y    = e.y;
        {hora, min, seg, dia, mes, year} = e.clk_vals;
        dir_prog = e.dir_prog;
        p_hora   = e.p_hora;
        p_fecha  = e.p_fecha;
        formato  = e.formato;
        am_pm    = e.am_pm;
        clk_parp = e.clk_parp;
    endtask

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_value(input string name, input logic [11:0] got,
                               input logic [11:0] exp);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    task automatic build_table();
        rng = 32'd75994;
        cur = '{default: '0};
        cur.dir_prog = screen_layout_pkg::EDIT_NONE;
        cur.formato  = 1'b1;
        cur.clk_parp = 1'b1;
        draw_clock_values();
        add_cell(0, 0, glyph_pkg::CORNER_UL, glyph_pkg::CLASS_FRAME, 1'b0);
        add_cell(39, 0, glyph_pkg::CORNER_UR, glyph_pkg::CLASS_FRAME, 1'b0);
        add_cell(39, 14, glyph_pkg::CORNER_DR, glyph_pkg::CLASS_FRAME, 1'b0);
        add_cell(0, 14, glyph_pkg::CORNER_DL, glyph_pkg::CLASS_FRAME, 1'b0);
        add_cell(20, 0, glyph_pkg::BORDER_TOP, glyph_pkg::CLASS_FRAME, 1'b0);
        add_cell(7, 14, glyph_pkg::BORDER_BOTTOM, glyph_pkg::CLASS_FRAME, 1'b0);
        add_cell(0, 5, glyph_pkg::BORDER_LEFT, glyph_pkg::CLASS_FRAME, 1'b0);
        add_cell(39, 10, glyph_pkg::BORDER_RIGHT, glyph_pkg::CLASS_FRAME, 1'b0);
        add_cell(12, 8, glyph_pkg::DIVIDER, glyph_pkg::CLASS_FRAME, 1'b0);
        add_cell(30, 11, glyph_pkg::CH_BLANK, glyph_pkg::CLASS_NONE, 1'b0);
        add_cell(12, 1, glyph_pkg::CH_BLANK, glyph_pkg::CLASS_NONE, 1'b0);  // gap cell
        for (int i = 0; i < 5; i++)
            add_cell(5 + i, 1, 7'(date_label[i]), glyph_pkg::CLASS_TEXT, 1'b0);
        for (int i = 0; i < 4; i++)
            add_cell(5 + i, 3, 7'(hour_label[i]), glyph_pkg::CLASS_TEXT, 1'b0);
        for (int k = 0; k < 2; k++)
        begin
            draw_clock_values();                // fresh values each pass
            for (int i = 0; i < 8; i++)
            begin
                add_cell(15 + i, 1, field_code(i, cur.clk_vals[23:0], glyph_pkg::CH_SLASH),
                         glyph_pkg::CLASS_TEXT, 1'b0);
                add_cell(15 + i, 3, field_code(i, cur.clk_vals[47:24], glyph_pkg::CH_COLON),
                         glyph_pkg::CLASS_TEXT, 1'b0);
            end
        end
        add_cell(23, 3, glyph_pkg::CH_BLANK, glyph_pkg::CLASS_TEXT, 1'b0);
        add_cell(24, 3, 7'h61, glyph_pkg::CLASS_TEXT, 1'b0);   // a
        add_cell(25, 3, 7'h6d, glyph_pkg::CLASS_TEXT, 1'b0);   // m
        cur.am_pm = 1'b1;
        add_cell(24, 3, 7'h70, glyph_pkg::CLASS_TEXT, 1'b0);   // p
        add_cell(25, 3, 7'h6d, glyph_pkg::CLASS_TEXT, 1'b0);
        cur.formato = 1'b0;                     // 24h mode drops the suffix
        add_cell(24, 3, glyph_pkg::CH_BLANK, glyph_pkg::CLASS_TEXT, 1'b0);
        add_cell(25, 3, glyph_pkg::CH_BLANK, glyph_pkg::CLASS_TEXT, 1'b0);

        // cursor blink on the hour row and then the date row
        cur.dir_prog = screen_layout_pkg::EDIT_HOUR;
        cur.p_hora   = 3'd3;
        cur.p_fecha  = 3'd5;
        cur.clk_parp = 1'b0;
        add_lit_cell(19, 3, field_code(4, cur.clk_vals[47:24], glyph_pkg::CH_COLON), 1'b1);
        add_lit_cell(18, 3, field_code(3, cur.clk_vals[47:24], glyph_pkg::CH_COLON), 1'b0);
        cur.clk_parp = 1'b1;
        add_lit_cell(19, 3, field_code(4, cur.clk_vals[47:24], glyph_pkg::CH_COLON), 1'b0);
        cur.dir_prog = screen_layout_pkg::EDIT_DATE;
        cur.clk_parp = 1'b0;
        add_lit_cell(22, 1, field_code(7, cur.clk_vals[23:0], glyph_pkg::CH_SLASH), 1'b1);
        add_lit_cell(22, 3, field_code(7, cur.clk_vals[47:24], glyph_pkg::CH_COLON),
                     1'b0);                     // hour row not in edit
        cur.dir_prog = screen_layout_pkg::EDIT_NONE;
        add_lit_cell(22, 1, field_code(7, cur.clk_vals[23:0], glyph_pkg::CH_SLASH), 1'b0);
    endtask

    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge nexys_clock);
        #1 rst_n = 1'b1;
    end

    initial
    begin
        // idle pixel off every region at glyph row 0
        pix_x    = 10'd288;
        pix_y    = 10'd288;
        {hora, min, seg, dia, mes, year} = '0;
        am_pm    = 1'b0;
        formato  = 1'b0;
        clk_parp = 1'b0;
        dir_prog = 2'd0;
        p_hora   = 3'd0;
        p_fecha  = 3'd0;
        build_table();

        waited = 0;
        do
        begin
            @(posedge nexys_clock);
            #3;
            waited++;
            check_value("font_addr", {1'b0, font_addr}, 12'h000);
            check_value("color", color, glyph_pkg::COLOR_BG);
            if (waited > RESET_TIMEOUT)
            begin
                $display("reset was not released in time");
                stop_on_error();
            end
        end
        while (rst_n !== 1'b1);

        // one pixel per cycle with results 2 and 4 edges later
        for (int c = 0; c < stim.size() + 4; c++)
        begin
            @(posedge nexys_clock);
            #1;
            if (c < 2)
                check_value("font_addr", {1'b0, font_addr}, 12'h000);
            else if (c - 2 < stim.size())
                check_value("font_addr", {1'b0, font_addr},
                            {1'b0, stim[c - 2].code, stim[c - 2].y[4:1]});
            if (c < 4)
                check_value("color", color, glyph_pkg::COLOR_BG);
            else
                check_value("color", color, expected_color(stim[c - 4]));
            if (c < stim.size())
                apply_entry(stim[c]);
        end

        if (i_dut.i_pixel_shader.i_props.fail_count == 0)
        begin
            $display("Test OK");
            $finish;
        end
        else
        begin
            $display("Test FAILED");
            $fatal(1, "bound assertions reported errors");
        end
    end

endmodule

//--- tb.f
hdl/screen_layout_pkg.sv
hdl/glyph_pkg.sv
hdl/clock_field_decoder.sv
hdl/frame_decoder.sv
hdl/pixel_shader.sv
hdl/char_overlay.sv
dv/char_overlay_props.sv
dv/char_overlay_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = char_overlay_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
RUNFLAGS  = +verilator+error+limit+100
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
